// ==== compile.f ====
+incdir+tests
logic/gt_ctrl_pkg.sv
logic/gt_lane_regs.sv
logic/gt_ctrl_bus.sv
logic/gt_ctrl_top.sv
tests/tb_gt_ctrl.sv

// ==== logic/gt_ctrl_bus.sv ====
`timescale 1ns/10ps

module gt_ctrl_bus #(
    parameter int NUM_LANES = 2
) (
    input  logic                                       wb_clk_i,
    input  logic                                       arst_n_i,
    input  logic                                       wb_cyc_i,
    input  logic                                       wb_stb_i,
    input  logic                                       wb_we_i,
    input  logic [gt_ctrl_pkg::WB_ADR_W-1:0]           wb_adr_i,
    input  logic [gt_ctrl_pkg::WB_DAT_W-1:0]           wb_dat_i,
    input  logic [gt_ctrl_pkg::WB_SEL_W-1:0]           wb_sel_i,
    input  logic                                       qpll_lock_i,
    input  gt_ctrl_pkg::status_word_t [NUM_LANES-1:0]  lane_status_i,
    output logic                                       wb_ack_o,
    output logic [gt_ctrl_pkg::WB_DAT_W-1:0]           wb_dat_o,
    output logic                                       xcvr_rst_o,
    output logic                                       qpll_lock_sync_o,
    output logic [NUM_LANES-1:0]                       wr_ctrl_o,
    output logic [NUM_LANES-1:0]                       wr_loopback_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic                                      req;
    logic                                      ctrl_wr;
    logic                                      loopback_wr;
    logic [LANE_W-1:0]                         lane_sel;
    logic                                      ack_q;
    logic                                      xcvr_rst_q;
    logic [gt_ctrl_pkg::SYNC_STAGES-1:0]       qpll_lock_sync;
    logic [gt_ctrl_pkg::WB_DAT_W-1:0]          rdata_q;

    assign req         = wb_cyc_i && wb_stb_i;
    assign ctrl_wr     = req && wb_we_i && wb_sel_i[0];
    assign loopback_wr = req && wb_we_i && wb_sel_i[1];
    assign lane_sel    = wb_adr_i[gt_ctrl_pkg::LANE_SEL_LSB +: LANE_W];

    // per-lane write strobes, only the addressed lane sees one
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_ctrl_o[i]     = ctrl_wr && (lane_sel == LANE_W'(i));
            wr_loopback_o[i] = loopback_wr && (lane_sel == LANE_W'(i));
        end
    end

    // ack follows every request cycle; shared reset takes any byte-0 write
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q      <= 1'b0;
            xcvr_rst_q <= 1'b0;
        end else begin
            ack_q <= req;
            if (ctrl_wr) begin
                xcvr_rst_q <= wb_dat_i[0];
            end
        end
    end

    // pll lock is asynchronous to the bus clock
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            qpll_lock_sync <= '0;
        end else begin
            qpll_lock_sync <= {qpll_lock_sync[gt_ctrl_pkg::SYNC_STAGES-2:0], qpll_lock_i};
        end
    end

    // read word is captured together with the ack
    always_ff @(posedge wb_clk_i) begin
        if (req && !wb_we_i) begin
            if (int'(lane_sel) < NUM_LANES) begin
                rdata_q <= lane_status_i[lane_sel];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // a master that drops cyc early must not see a stale ack
    assign wb_ack_o         = ack_q && wb_cyc_i;
    assign wb_dat_o         = rdata_q;
    assign xcvr_rst_o       = xcvr_rst_q;
    assign qpll_lock_sync_o = qpll_lock_sync[gt_ctrl_pkg::SYNC_STAGES-1];

    ack_needs_request : assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
    ) else $error("ack without a preceding bus request");

endmodule

// ==== logic/gt_ctrl_pkg.sv ====
package gt_ctrl_pkg;

    // transceiver loopback code, as the GT primitive takes it
    typedef logic [2:0] loopback_t;

    // per-lane DMONITOR value from the transceiver
    typedef logic [15:0] dmon_t;

    // status word returned on a lane read, bit 0 first from the bottom
    typedef struct packed {
        dmon_t      dmon;
        logic [4:0] zero_hi;
        loopback_t  loopback;
        logic [2:0] zero_lo;
        logic       eye_rst;
        logic       high_ber;
        logic       block_lock;
        logic       qpll_lock;
        logic       xcvr_rst;
    } status_word_t;

    // wishbone target geometry
    localparam int WB_ADR_W = 13;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // lowest address bit that picks the lane (one word per lane)
    localparam int LANE_SEL_LSB = 2;

    // flop count on every asynchronous status input
    localparam int SYNC_STAGES = 2;

endpackage

// ==== logic/gt_ctrl_top.sv ====
`timescale 1ns/10ps

module gt_ctrl_top #(
    parameter int NUM_LANES = 2
) (
    input  logic                                       wb_clk_i,
    input  logic                                       arst_n_i,
    input  logic                                       wb_cyc_i,
    input  logic                                       wb_stb_i,
    input  logic                                       wb_we_i,
    input  logic [gt_ctrl_pkg::WB_ADR_W-1:0]           wb_adr_i,
    input  logic [gt_ctrl_pkg::WB_DAT_W-1:0]           wb_dat_i,
    input  logic [gt_ctrl_pkg::WB_SEL_W-1:0]           wb_sel_i,
    input  logic                                       qpll_lock_i,
    input  logic [NUM_LANES-1:0]                       rx_block_lock_i,
    input  logic [NUM_LANES-1:0]                       rx_high_ber_i,
    input  gt_ctrl_pkg::dmon_t [NUM_LANES-1:0]         dmonitor_i,
    output logic                                       wb_ack_o,
    output logic [gt_ctrl_pkg::WB_DAT_W-1:0]           wb_dat_o,
    output logic                                       xcvr_rst_o,
    output logic [NUM_LANES-1:0]                       eye_rst_o,
    output gt_ctrl_pkg::loopback_t [NUM_LANES-1:0]     loopback_o,
    output logic [NUM_LANES-1:0]                       sfp_led_o
);

    gt_ctrl_pkg::status_word_t [NUM_LANES-1:0]  lane_status;
    logic [NUM_LANES-1:0]                       wr_ctrl;
    logic [NUM_LANES-1:0]                       wr_loopback;
    logic                                       qpll_lock_sync;

    // bus side: decode, shared reset, pll lock sync and read path
    gt_ctrl_bus #(
        .NUM_LANES(NUM_LANES)
    ) u_bus (
        .wb_clk_i         (wb_clk_i),
        .arst_n_i         (arst_n_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_sel_i         (wb_sel_i),
        .qpll_lock_i      (qpll_lock_i),
        .lane_status_i    (lane_status),
        .wb_ack_o         (wb_ack_o),
        .wb_dat_o         (wb_dat_o),
        .xcvr_rst_o       (xcvr_rst_o),
        .qpll_lock_sync_o (qpll_lock_sync),
        .wr_ctrl_o        (wr_ctrl),
        .wr_loopback_o    (wr_loopback)
    );

    // one register block per SFP lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        gt_lane_regs u_lane (
            .wb_clk_i        (wb_clk_i),
            .arst_n_i        (arst_n_i),
            .wr_ctrl_i       (wr_ctrl[i]),
            .wr_loopback_i   (wr_loopback[i]),
            .wdata_i         (wb_dat_i),
            .xcvr_rst_i      (xcvr_rst_o),
            .qpll_lock_i     (qpll_lock_sync),
            .rx_block_lock_i (rx_block_lock_i[i]),
            .rx_high_ber_i   (rx_high_ber_i[i]),
            .dmonitor_i      (dmonitor_i[i]),
            .status_o        (lane_status[i]),
            .eye_rst_o       (eye_rst_o[i]),
            .loopback_o      (loopback_o[i]),
            .led_o           (sfp_led_o[i])
        );
    end

endmodule

// ==== logic/gt_lane_regs.sv ====
`timescale 1ns/10ps

module gt_lane_regs (
    input  logic                                  wb_clk_i,
    input  logic                                  arst_n_i,
    input  logic                                  wr_ctrl_i,
    input  logic                                  wr_loopback_i,
    input  logic [gt_ctrl_pkg::WB_DAT_W-1:0]      wdata_i,
    input  logic                                  xcvr_rst_i,
    input  logic                                  qpll_lock_i,
    input  logic                                  rx_block_lock_i,
    input  logic                                  rx_high_ber_i,
    input  gt_ctrl_pkg::dmon_t                    dmonitor_i,
    output gt_ctrl_pkg::status_word_t             status_o,
    output logic                                  eye_rst_o,
    output gt_ctrl_pkg::loopback_t                loopback_o,
    output logic                                  led_o
);

    // positions of the control fields in a write word
    localparam int EYE_RST_BIT  = 4;
    localparam int LOOPBACK_LSB = 8;
    localparam int LOOPBACK_W   = $bits(gt_ctrl_pkg::loopback_t);

    logic                                  eye_rst_q;
    gt_ctrl_pkg::loopback_t                loopback_q;
    logic [gt_ctrl_pkg::SYNC_STAGES-1:0]   block_lock_sync;
    logic [gt_ctrl_pkg::SYNC_STAGES-1:0]   high_ber_sync;
    logic                                  block_lock_s;
    logic                                  high_ber_s;

    // control registers, written through the strobes from the bus block
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            eye_rst_q  <= 1'b0;
            loopback_q <= '0;
        end else begin
            if (wr_ctrl_i) begin
                eye_rst_q <= wdata_i[EYE_RST_BIT];
            end
            if (wr_loopback_i) begin
                loopback_q <= wdata_i[LOOPBACK_LSB +: LOOPBACK_W];
            end
        end
    end

    // block lock and high-BER come from the lane's rx clock
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            block_lock_sync <= '0;
            high_ber_sync   <= '0;
        end else begin
            block_lock_sync <= {block_lock_sync[gt_ctrl_pkg::SYNC_STAGES-2:0], rx_block_lock_i};
            high_ber_sync   <= {high_ber_sync[gt_ctrl_pkg::SYNC_STAGES-2:0], rx_high_ber_i};
        end
    end

    assign block_lock_s = block_lock_sync[gt_ctrl_pkg::SYNC_STAGES-1];
    assign high_ber_s   = high_ber_sync[gt_ctrl_pkg::SYNC_STAGES-1];

    // monitor value and control bits go in without delay
    always_comb begin
        status_o            = '0;
        status_o.xcvr_rst   = xcvr_rst_i;
        status_o.qpll_lock  = qpll_lock_i;
        status_o.block_lock = block_lock_s;
        status_o.high_ber   = high_ber_s;
        status_o.eye_rst    = eye_rst_q;
        status_o.loopback   = loopback_q;
        status_o.dmon       = dmonitor_i;
    end

    assign eye_rst_o  = eye_rst_q;
    assign loopback_o = loopback_q;
    // LED lights once the lane has block lock
    assign led_o      = block_lock_s;

    // the transceiver must never see a loopback change it was not told about
    loopback_only_on_write : assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        !$stable(loopback_q) |-> $past(wr_loopback_i)
    ) else $error("loopback code changed without a loopback write");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_gt_ctrl \
    -Mdir obj_dir \
    -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_gt_ctrl
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== tests/tb_gt_ctrl_vectors.svh ====
`ifndef TB_GT_CTRL_VECTORS_SVH
`define TB_GT_CTRL_VECTORS_SVH

// each row holds op, lane, write data, byte enables, block lock [1:0], high-BER [1:0],
//          pll lock, expected xcvr reset, expected eye reset [1:0], expected loopback lane 0, 1
function automatic void load_vectors();
    // reset state, both lanes read back empty
    add_row(RD, 1'b0, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b0, 2'b00, 3'd0, 3'd0);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b0, 2'b00, 3'd0, 3'd0);
    // shared reset through lane 0, seen by both lanes
    add_row(WR, 1'b0, 32'h0000_0001, 4'b0001, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd0, 3'd0);
    add_row(RD, 1'b0, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd0, 3'd0);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd0, 3'd0);
    // loopback codes land only in the addressed lane
    add_row(WR, 1'b0, 32'h0000_0500, 4'b0010, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd5, 3'd0);
    add_row(WR, 1'b1, 32'h0000_0200, 4'b0010, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd5, 3'd2);
    add_row(RD, 1'b0, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd5, 3'd2);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b1, 2'b00, 3'd5, 3'd2);
    // eye reset on lane 1, shared reset kept high by data bit 0
    add_row(WR, 1'b1, 32'h0000_0011, 4'b0001, 2'b00, 2'b00, 1'b0, 1'b1, 2'b10, 3'd5, 3'd2);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b1, 2'b10, 3'd5, 3'd2);
    add_row(RD, 1'b0, 32'h0000_0000, 4'b0000, 2'b00, 2'b00, 1'b0, 1'b1, 2'b10, 3'd5, 3'd2);
    // no matching byte enable, nothing moves
    add_row(WR, 1'b0, 32'h0000_0711, 4'b1100, 2'b00, 2'b00, 1'b0, 1'b1, 2'b10, 3'd5, 3'd2);
    add_row(WR, 1'b1, 32'h0000_0000, 4'b1100, 2'b00, 2'b00, 1'b0, 1'b1, 2'b10, 3'd5, 3'd2);
    // status inputs in their fields, LEDs follow block lock
    add_row(RD, 1'b0, 32'h0000_0000, 4'b0000, 2'b01, 2'b10, 1'b1, 1'b1, 2'b10, 3'd5, 3'd2);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b01, 2'b10, 1'b1, 1'b1, 2'b10, 3'd5, 3'd2);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b10, 2'b01, 1'b0, 1'b1, 2'b10, 3'd5, 3'd2);
    // clear reset and loopback, set lane 0 eye reset in one write
    add_row(WR, 1'b0, 32'h0000_0010, 4'b0011, 2'b10, 2'b01, 1'b0, 1'b0, 2'b11, 3'd0, 3'd2);
    add_row(RD, 1'b0, 32'h0000_0000, 4'b0000, 2'b11, 2'b01, 1'b1, 1'b0, 2'b11, 3'd0, 3'd2);
    add_row(RD, 1'b1, 32'h0000_0000, 4'b0000, 2'b11, 2'b01, 1'b1, 1'b0, 2'b11, 3'd0, 3'd2);
endfunction

`endif

// ==== tests/tb_gt_ctrl.sv ====
`timescale 1ns/10ps

module tb_gt_ctrl;

    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_ROW = 20;
    localparam int ACK_TIMEOUT    = 8;
    localparam int HOLD_CYCLES    = 4;
    localparam bit RD             = 1'b0;
    localparam bit WR             = 1'b1;
    // write-data bits with a meaning: shared reset, eye reset, loopback
    localparam logic [31:0] USED_BITS = 32'h0000_0711;

    typedef struct packed {
        logic                   is_write;
        logic                   lane;
        logic [31:0]            wdata;
        logic [3:0]             sel;
        logic [1:0]             block_lock;
        logic [1:0]             high_ber;
        logic                   pll_lock;
        logic                   exp_rst;
        logic [1:0]             exp_eye;
        gt_ctrl_pkg::loopback_t exp_lb0;
        gt_ctrl_pkg::loopback_t exp_lb1;
    } vector_t;

    logic                                   wb_clk = 1'b0;
    logic                                   arst_n;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic                                   wb_we;
    logic [gt_ctrl_pkg::WB_ADR_W-1:0]       wb_adr;
    logic [gt_ctrl_pkg::WB_DAT_W-1:0]       wb_dat_w;
    logic [gt_ctrl_pkg::WB_SEL_W-1:0]       wb_sel;
    logic                                   qpll_lock;
    logic [1:0]                             rx_block_lock;
    logic [1:0]                             rx_high_ber;
    gt_ctrl_pkg::dmon_t [1:0]               dmonitor;
    logic                                   wb_ack;
    logic [gt_ctrl_pkg::WB_DAT_W-1:0]       wb_dat_r;
    logic                                   xcvr_rst;
    logic [1:0]                             eye_rst;
    gt_ctrl_pkg::loopback_t [1:0]           loopback;
    logic [1:0]                             sfp_led;

    vector_t     vectors[$];
    logic        table_ready = 1'b0;
    logic [31:0] lfsr_state  = 32'ha0b50d81;

    gt_ctrl_top DUT (
        .wb_clk_i        (wb_clk),
        .arst_n_i        (arst_n),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_dat_i        (wb_dat_w),
        .wb_sel_i        (wb_sel),
        .qpll_lock_i     (qpll_lock),
        .rx_block_lock_i (rx_block_lock),
        .rx_high_ber_i   (rx_high_ber),
        .dmonitor_i      (dmonitor),
        .wb_ack_o        (wb_ack),
        .wb_dat_o        (wb_dat_r),
        .xcvr_rst_o      (xcvr_rst),
        .eye_rst_o       (eye_rst),
        .loopback_o      (loopback),
        .sfp_led_o       (sfp_led)
    );

    always #2 wb_clk = ~wb_clk;

    function automatic void add_row(input logic is_write, input logic lane,
                                    input logic [31:0] wdata, input logic [3:0] sel,
                                    input logic [1:0] block_lock, input logic [1:0] high_ber,
                                    input logic pll_lock, input logic exp_rst,
                                    input logic [1:0] exp_eye,
                                    input gt_ctrl_pkg::loopback_t exp_lb0,
                                    input gt_ctrl_pkg::loopback_t exp_lb1);
        vectors.push_back({is_write, lane, wdata, sel, block_lock, high_ber, pll_lock,
                           exp_rst, exp_eye, exp_lb0, exp_lb1});
    endfunction

    `include "tb_gt_ctrl_vectors.svh"

    // taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_loopback(input string name, input gt_ctrl_pkg::loopback_t got,
                                  input gt_ctrl_pkg::loopback_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input gt_ctrl_pkg::status_word_t got,
                                input gt_ctrl_pkg::status_word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // one single-beat cycle, request held until ack, then dropped
    task automatic bus_xfer(input logic we, input logic lane, input logic [31:0] data,
                            input logic [3:0] sel, output gt_ctrl_pkg::status_word_t rdata);
        int waited;
        waited = 0;
        @(posedge wb_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= gt_ctrl_pkg::WB_ADR_W'(lane) << gt_ctrl_pkg::LANE_SEL_LSB;
        wb_dat_w <= data;
        wb_sel   <= sel;
        @(negedge wb_clk);
        while (!wb_ack) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                $display("no ack from the DUT within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
                abort_run();
            end
            @(negedge wb_clk);
        end
        rdata = wb_dat_r;
        @(posedge wb_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge wb_clk);
    endtask

    task automatic apply_row(input vector_t v);
        gt_ctrl_pkg::dmon_t [1:0]  dmon;
        logic [31:0]               wdata;
        gt_ctrl_pkg::status_word_t rdata;
        gt_ctrl_pkg::status_word_t exp_word;
        dmon[0] = gt_ctrl_pkg::dmon_t'(rand_bits(16));
        dmon[1] = gt_ctrl_pkg::dmon_t'(rand_bits(16));
        wdata   = (v.wdata & USED_BITS) | (rand_bits(32) & ~USED_BITS);
        @(posedge wb_clk);
        rx_block_lock <= v.block_lock;
        rx_high_ber   <= v.high_ber;
        qpll_lock     <= v.pll_lock;
        dmonitor      <= dmon;
        // let the synchronizers settle before a read
        if (!v.is_write) begin
            repeat (HOLD_CYCLES) @(posedge wb_clk);
        end
        bus_xfer(v.is_write, v.lane, wdata, v.sel, rdata);
        check_bit("xcvr_rst_o", xcvr_rst, v.exp_rst);
        check_bit("eye_rst_o[0]", eye_rst[0], v.exp_eye[0]);
        check_bit("eye_rst_o[1]", eye_rst[1], v.exp_eye[1]);
        check_loopback("loopback_o[0]", loopback[0], v.exp_lb0);
        check_loopback("loopback_o[1]", loopback[1], v.exp_lb1);
        if (!v.is_write) begin
            exp_word            = '0;
            exp_word.xcvr_rst   = v.exp_rst;
            exp_word.qpll_lock  = v.pll_lock;
            exp_word.block_lock = v.block_lock[v.lane];
            exp_word.high_ber   = v.high_ber[v.lane];
            exp_word.eye_rst    = v.exp_eye[v.lane];
            exp_word.loopback   = v.lane ? v.exp_lb1 : v.exp_lb0;
            exp_word.dmon       = dmon[v.lane];
            check_status("wb_dat_o", rdata, exp_word);
            check_bit("sfp_led_o[0]", sfp_led[0], v.block_lock[0]);
            check_bit("sfp_led_o[1]", sfp_led[1], v.block_lock[1]);
        end
    endtask

    // watchdog, sized from the table once it is loaded
    initial begin
        wait (table_ready);
        repeat (vectors.size() * CYCLES_PER_ROW + RESET_CYCLES) @(posedge wb_clk);
        $display("watchdog expired before the vector table finished at %0t ns", $time);
        abort_run();
    end

    initial begin
        arst_n        = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        wb_sel        = '0;
        qpll_lock     = 1'b0;
        rx_block_lock = '0;
        rx_high_ber   = '0;
        dmonitor      = '0;
        load_vectors();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge wb_clk);
        arst_n <= 1'b1;
        @(negedge wb_clk);
        check_bit("wb_ack_o", wb_ack, 1'b0);
        foreach (vectors[i]) begin
            apply_row(vectors[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
